// ==== run_sim.sh ====
#!/bin/bash
# Build and run the TEA coprocessor testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_tea_coprocessor \
	-o tb_sim 2>&1 | tee build.log \
	&& ./obj_dir/tb_sim 2>&1 | tee sim.log \
	&& grep -q "Simulation finished: PASS" sim.log \
	&& echo "run_sim: passed" \
	|| { echo "run_sim: failed"; exit 1; }

// ==== tb_tea_coprocessor.sv ====
/*
 * TEA coprocessor testbench
 *
 * Reads command vectors from the data file and drives them into the
 * coprocessor. Each result is checked against a TEA reference model
 * that follows the round rule. Also checks encrypt latency,
 * back-pressure and the ignored function codes.
 */

`timescale 1ns/10ps

module tb_tea_coprocessor
	import tea_pkg::*;
;

	localparam int ROUNDS    = 32;
	localparam int NUM_VEC   = 8;
	localparam int MAX_CYCLE = NUM_VEC * (ROUNDS + 20) + 200;

	logic        clk;
	logic        reset;
	logic        cmd_valid;
	tea_cmd_t    cmd;
	logic        cmd_ready;
	logic        rsp_valid;
	logic        rsp_ready;
	word_t       rsp_word;

	logic [95:0] vec_mem [0:NUM_VEC-1];
	int          seed;
	int          error_count;
	int          tests_passed;
	int          tests_failed;
	int          cycle_count;
	word_t       model_high;

	tea_coprocessor #(
		.ROUNDS (ROUNDS)
	) uut (
		.clk       (clk),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_word  (rsp_word)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	////////////////////
	// Timeout
	////////////////////

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLE)
		begin
			$display("Run stopped: no progress after %0d cycles, the DUT seems stuck", MAX_CYCLE);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////
	// Reference and checks
	////////////////////

	// Plain TEA encryption returning {v1, v0}
	function automatic logic [63:0] tea_reference(input word_t y, input word_t z);
		word_t acc;

		acc = 32'd0;
		for (int i = 0; i < ROUNDS; i++)
		begin
			acc = acc + TEA_DELTA;
			y = y + (((z << 4) + TEA_KEY0) ^ (z + acc) ^ ((z >> 5) + TEA_KEY1));
			z = z + (((y << 4) + TEA_KEY2) ^ (y + acc) ^ ((y >> 5) + TEA_KEY3));
		end
		return {z, y};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERR t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	// Present a command and leave after the accepting edge
	task automatic send_command(input func_id_t func, input word_t w0, input word_t w1);
		@(negedge clk);
		check_value("cmd_ready", 32'(cmd_ready), 32'd1);
		cmd.function_id = func;
		cmd.word0       = w0;
		cmd.word1       = w1;
		cmd_valid       = 1'b1;
		@(posedge clk);
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	// Edges after acceptance until rsp_valid
	task automatic wait_response(output int edges);
		edges = 0;
		while (!rsp_valid)
		begin
			check_value("cmd_ready", 32'(cmd_ready), 32'd0);
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
	endtask

	// Stall for a random time, then complete the handshake
	task automatic take_response(input word_t expected);
		int    stall;
		word_t first;

		stall = ($random(seed) & 32'h7);
		first = rsp_word;
		check_value("rsp_word", rsp_word, expected);
		check_value("cmd_ready", 32'(cmd_ready), 32'd0);
		repeat (stall)
		begin
			@(negedge clk);
			check_value("rsp_valid", 32'(rsp_valid), 32'd1);
			check_value("cmd_ready", 32'(cmd_ready), 32'd0);
			check_value("rsp_word", rsp_word, first);
		end
		rsp_ready = 1'b1;
		@(posedge clk);
		@(negedge clk);
		rsp_ready = 1'b0;
		check_value("rsp_valid", 32'(rsp_valid), 32'd0);
		check_value("cmd_ready", 32'(cmd_ready), 32'd1);
	endtask

	task automatic read_high_word();
		int edges;

		send_command(10'd1, 32'd0, 32'd0);
		wait_response(edges);
		check_value("read_high_latency", 32'(edges), 32'd0);
		take_response(model_high);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		logic [63:0] expected;
		int          edges;
		int          errors_before;
		logic [1:0]  code;

		seed         = 28;
		error_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycle_count  = 0;
		model_high   = 32'd0;
		reset        = 1'b1;
		cmd_valid    = 1'b0;
		cmd          = '0;
		rsp_ready    = 1'b0;
		$readmemh("tea_testdata.hex", vec_mem);

		repeat (2)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_value("cmd_ready", 32'(cmd_ready), 32'd1);
		check_value("rsp_valid", 32'(rsp_valid), 32'd0);

		for (int i = 0; i < NUM_VEC; i++)
		begin
			errors_before = error_count;
			code          = vec_mem[i][65:64];
			if (code == FUNC_ENCRYPT)
			begin
				expected = tea_reference(vec_mem[i][63:32], vec_mem[i][31:0]);
				send_command(vec_mem[i][73:64], vec_mem[i][63:32], vec_mem[i][31:0]);
				wait_response(edges);
				check_value("encrypt_latency", 32'(edges), 32'(ROUNDS));
				take_response(expected[31:0]);
				model_high = expected[63:32];
				read_high_word();
			end
			else if (code == FUNC_READ_HIGH)
			begin
				read_high_word();
			end
			else
			begin
				send_command(vec_mem[i][73:64], vec_mem[i][63:32], vec_mem[i][31:0]);
				repeat (40)
				begin
					check_value("rsp_valid", 32'(rsp_valid), 32'd0);
					check_value("cmd_ready", 32'(cmd_ready), 32'd1);
					@(negedge clk);
				end
				read_high_word();
			end
			if (error_count == errors_before)
			begin
				tests_passed++;
				$display("test %0d code %0d ok", i, code);
			end
			else
			begin
				tests_failed++;
				$display("test %0d code %0d failed", i, code);
			end
		end

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== tea_assertions.sv ====
/*
 * TEA coprocessor protocol assertions
 *
 * Bound to the top level. Checks the command and response handshake.
 */

`timescale 1ns/10ps

module tea_assertions
	import tea_pkg::*;
(
	input logic  clk,
	input logic  reset,
	input logic  cmd_ready,
	input logic  rsp_valid,
	input logic  rsp_ready,
	input word_t rsp_word
);

	// Completed response frees the block for the next command
	assert property (@(posedge clk) disable iff (reset)
		(rsp_valid && rsp_ready) |=> (cmd_ready && !rsp_valid))
		else $error("cmd_ready not high after completed response");

	// Held response under back-pressure
	assert property (@(posedge clk) disable iff (reset)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_word)))
		else $error("response changed while stalled");

	assert property (@(posedge clk) $fell(reset) |-> cmd_ready)
		else $error("cmd_ready low after reset");

endmodule

bind tea_coprocessor tea_assertions u_assertions
(
	.clk       (clk),
	.reset     (reset),
	.cmd_ready (cmd_ready),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.rsp_word  (rsp_word)
);

// ==== tea_coprocessor.sv ====
/*
 * TEA custom-instruction coprocessor
 *
 * Encrypts a 64-bit block with the Tiny Encryption Algorithm under a
 * fixed key. Code 0 encrypts and returns v0, code 1 returns v1 of the
 * last result. One command is in flight at a time.
 */

`timescale 1ns/10ps

module tea_coprocessor
	import tea_pkg::*;
#(
	parameter int ROUNDS = 32
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     cmd_valid,
	input  tea_cmd_t cmd,
	output logic     cmd_ready,
	output logic     rsp_valid,
	input  logic     rsp_ready,
	output word_t    rsp_word
);

	logic load;
	logic round_en;
	logic select_high;
	logic last_round;

	////////////////////
	// Control
	////////////////////

	tea_ctrl_fsm u_ctrl
	(
		.clk         (clk),
		.reset       (reset),
		.cmd_valid   (cmd_valid),
		.function_id (cmd.function_id),
		.last_round  (last_round),
		.rsp_ready   (rsp_ready),
		.cmd_ready   (cmd_ready),
		.load        (load),
		.round_en    (round_en),
		.select_high (select_high),
		.rsp_valid   (rsp_valid)
	);

	tea_round_counter #(
		.ROUNDS (ROUNDS)
	) u_counter (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.round_en   (round_en),
		.last_round (last_round)
	);

	////////////////////
	// Datapath
	////////////////////

	tea_round_datapath u_datapath
	(
		.clk         (clk),
		.reset       (reset),
		.cmd         (cmd),
		.load        (load),
		.round_en    (round_en),
		.select_high (select_high),
		.rsp_word    (rsp_word)
	);

endmodule

// ==== tea_ctrl_fsm.sv ====
/*
 * TEA coprocessor control
 *
 * Accepts one command at a time, starts the round sequence for an
 * encrypt, and holds the response until the CPU takes it. Codes 2
 * and 3 are accepted and dropped.
 */

`timescale 1ns/10ps

module tea_ctrl_fsm
	import tea_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     cmd_valid,
	input  func_id_t function_id,
	input  logic     last_round,
	input  logic     rsp_ready,
	output logic     cmd_ready,
	output logic     load,
	output logic     round_en,
	output logic     select_high,
	output logic     rsp_valid
);

	typedef enum logic [1:0]
	{
		IDLE,
		ROUND,
		RESPOND
	} tea_state_t;

	tea_state_t state;
	tea_state_t state_next;
	logic       accept;
	logic [1:0] func_code;

	////////////////////
	// Decode
	////////////////////

	assign func_code = function_id[1:0];
	assign accept    = cmd_valid & cmd_ready;

	////////////////////
	// State register
	////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (accept)
				begin
					if (func_code == FUNC_ENCRYPT)
						state_next = ROUND;
					else if (func_code == FUNC_READ_HIGH)
						state_next = RESPOND;
				end
			end
			ROUND:
			begin
				// Counter flags the final round cycle
				if (last_round)
					state_next = RESPOND;
			end
			RESPOND:
			begin
				if (rsp_ready)
					state_next = IDLE;
			end
			default:
			begin
				state_next = IDLE;
			end
		endcase
	end

	////////////////////
	// Response word select
	////////////////////

	// Ignored codes keep the previous selection
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			select_high <= 1'b0;
		else if (accept)
		begin
			if (func_code == FUNC_ENCRYPT)
				select_high <= 1'b0;
			else if (func_code == FUNC_READ_HIGH)
				select_high <= 1'b1;
		end
	end

	////////////////////
	// Outputs
	////////////////////

	assign cmd_ready = (state == IDLE);
	assign load      = accept & (func_code == FUNC_ENCRYPT);
	assign round_en  = (state == ROUND);
	assign rsp_valid = (state == RESPOND);

endmodule

// ==== tea_pkg.sv ====
/*
 * TEA coprocessor shared definitions
 *
 * Data word and function id types, the command and block structs,
 * the delta and key constants, and the decoded function codes of the
 * custom-instruction TEA encryption block.
 */

package tea_pkg;

	////////////////////
	// Basic types
	////////////////////

	// One 32-bit TEA half-block, operand or response
	typedef logic [31:0] word_t;

	// Full function id from the CPU; only [1:0] is decoded
	typedef logic [9:0] func_id_t;

	////////////////////
	// Structs
	////////////////////

	// Command as presented with cmd_valid
	typedef struct packed
	{
		func_id_t function_id;
		word_t    word0;
		word_t    word1;
	} tea_cmd_t;

	// 64-bit block, high word first
	typedef struct packed
	{
		word_t v1;
		word_t v0;
	} tea_block_t;

	////////////////////
	// TEA constants
	////////////////////

	// Golden ratio based round constant
	localparam word_t TEA_DELTA = 32'h9E37_79B9;

	// Fixed 128-bit key
	localparam word_t TEA_KEY0  = 32'h0123_4567;
	localparam word_t TEA_KEY1  = 32'h89AB_CDEF;
	localparam word_t TEA_KEY2  = 32'h1357_9248;
	localparam word_t TEA_KEY3  = 32'h248A_0135;

	////////////////////
	// Function codes
	////////////////////

	// Run the rounds, answer with v0
	localparam logic [1:0] FUNC_ENCRYPT   = 2'd0;

	// Answer with v1 of the stored block
	localparam logic [1:0] FUNC_READ_HIGH = 2'd1;

endpackage

// ==== tea_round_counter.sv ====
/*
 * TEA round counter
 *
 * Counts completed rounds of the current encryption and flags the
 * final one. ROUNDS must be a power of two, 2 or more.
 */

`timescale 1ns/10ps

module tea_round_counter #(
	parameter int ROUNDS = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic round_en,
	output logic last_round
);

	localparam int CNT_W = $clog2(ROUNDS);

	typedef logic [CNT_W-1:0] round_cnt_t;

	localparam round_cnt_t LAST_COUNT = round_cnt_t'(ROUNDS - 1);

	round_cnt_t round_cnt;

	////////////////////
	// Count
	////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			round_cnt <= '0;
		else if (load)
			round_cnt <= '0;
		else if (round_en)
			round_cnt <= round_cnt + 1'b1;
	end

	// High during the cycle whose edge performs the last round
	assign last_round = round_en & (round_cnt == LAST_COUNT);

endmodule

// ==== tea_round_datapath.sv ====
/*
 * TEA round datapath
 *
 * Holds the v0/v1 block and the running sum, applies one TEA round
 * per enabled cycle with the fixed key, and selects the response
 * word. The block is kept between commands for the read-high code.
 */

`timescale 1ns/10ps

module tea_round_datapath
	import tea_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  tea_cmd_t cmd,
	input  logic     load,
	input  logic     round_en,
	input  logic     select_high,
	output word_t    rsp_word
);

	tea_block_t data_block;
	tea_block_t block_next;
	word_t      sum;

	////////////////////
	// Round function
	////////////////////

	// Shift/add/xor mix shared by both halves of a round
	function automatic word_t tea_mix(
		input word_t v,
		input word_t key_a,
		input word_t key_b,
		input word_t sum_in
	);
		word_t top;
		word_t mid;
		word_t bot;

		top = (v << 4) + key_a;
		mid = v + sum_in;
		bot = (v >> 5) + key_b;
		return top ^ mid ^ bot;
	endfunction

	always_comb
	begin
		block_next.v0 = data_block.v0 + tea_mix(data_block.v1, TEA_KEY0, TEA_KEY1, sum);
		// Second half works on the updated v0
		block_next.v1 = data_block.v1 + tea_mix(block_next.v0, TEA_KEY2, TEA_KEY3, sum);
	end

	////////////////////
	// Block and sum registers
	////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			data_block <= '0;
			sum        <= '0;
		end
		else if (load)
		begin
			data_block.v0 <= cmd.word0;
			data_block.v1 <= cmd.word1;
			sum           <= TEA_DELTA;
		end
		else if (round_en)
		begin
			data_block <= block_next;
			sum        <= sum + TEA_DELTA;
		end
	end

	////////////////////
	// Response
	////////////////////

	assign rsp_word = select_high ? data_block.v1 : data_block.v0;

endmodule

// ==== tea_testdata.hex ====
// Columns: function id (low 10 bits used), word0 (v0), word1 (v1)
// Expected words come from the TEA round rule with 32 rounds
00000000_00000000_00000000
00000000_01234567_89abcdef
00000000_ffffffff_ffffffff
00000002_deadbeef_cafef00d
00000001_00000000_00000000
00000000_a5a5a5a5_5a5a5a5a
00000003_11111111_22222222
00000004_13579bdf_2468ace0

// ==== vlog.f ====
tea_pkg.sv
tea_ctrl_fsm.sv
tea_round_counter.sv
tea_round_datapath.sv
tea_coprocessor.sv
tea_assertions.sv
tb_tea_coprocessor.sv
